// ==== filelist.f ====
+incdir+tests
src/audio_cfg_pkg.sv
src/usb_proto_pkg.sv
src/sample_fifo.sv
src/dac_slot_driver.sv
src/config_registers.sv
src/fx2_ep2_reader.sv
src/usb_audio_top.sv
tests/tb_usb_audio.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds with Verilator and runs; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_usb_audio \
    -o sim_tb > sim.log 2>&1 && ./obj_dir/sim_tb >> sim.log 2>&1 || {
    echo "Build or run error, see sim.log"
    exit 1
}
grep -q "Simulation finished: FAIL" sim.log && {
    echo "Simulation reported failure, see sim.log"
    exit 1
}
grep -q "Simulation finished: PASS" sim.log || { echo "No result in sim.log"; exit 1; }
exit 0

// ==== tests/fx2_host_model.svh ====
// Included inside the testbench module; expects NUM_PORTS and both packages visible there

// Bytes waiting in the EP2 endpoint with the head on usb_data_out
logic [7:0]          ep2_q [$];
// One expected byte queue per DAC port
logic [SAMPLE_W-1:0] exp_q [NUM_PORTS][$];
logic [31:0]         rng_state = 32'd35433;

// xorshift32
function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Data packet with random payload that is also queued as expected output
task automatic send_data(input int port, input int len);
    ep2_header_u hdr;
    logic [31:0] r;
    hdr = '0;
    hdr.data.kind = HDR_KIND_DATA;
    hdr.data.port = PORT_SEL_W'(port);
    hdr.data.len  = LEN_W'(len);
    ep2_q.push_back(hdr);
    for (int i = 0; i < len; i++) begin
        r = next_random();
        ep2_q.push_back(r[7:0]);
        exp_q[port].push_back(r[SAMPLE_W-1:0]);
    end
endtask

// Command header then its value byte
task automatic send_cmd(input logic [CFG_ADDR_W-1:0] addr, input logic [7:0] value);
    ep2_header_u hdr;
    hdr = '0;
    hdr.cmd.kind = HDR_KIND_CMD;
    hdr.cmd.addr = addr;
    ep2_q.push_back(hdr);
    ep2_q.push_back(value);
endtask

// ==== tests/tb_usb_audio.sv ====
// Runs usb_audio_top with default parameters; the run is bounded by a cycle watchdog
`timescale 1ns/1ps

module tb_usb_audio
    import usb_proto_pkg::*;
    import audio_cfg_pkg::*;
();

    localparam int NUM_PORTS       = 4;
    localparam int FIFO_DEPTH      = 16;
    localparam int RESET_DIV       = 3;
    localparam int PACE_DIV        = 5;
    localparam int MAX_DIV         = 7;
    // Upper bound on EP2 bytes over all tests
    localparam int TOTAL_BYTES     = 200;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * (MAX_DIV + 2) + 500;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          usb_ep2_empty;
    logic [7:0]                    usb_data_out;
    logic                          usb_slrd;
    logic                          usb_sloe;
    logic [1:0]                    usb_addr;
    logic [NUM_PORTS*SAMPLE_W-1:0] slot_data_out;
    logic [NUM_PORTS-1:0]          slot_strobe;
    logic [NUM_PORTS-1:0]          underflow;
    int errors = 0;
    int start_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    `include "fx2_host_model.svh"

    usb_audio_top u_dut (
        .clk(clk), .reset(reset),
        .usb_ep2_empty(usb_ep2_empty), .usb_data_out(usb_data_out),
        .usb_slrd(usb_slrd), .usb_sloe(usb_sloe), .usb_addr(usb_addr),
        .slot_data_out(slot_data_out), .slot_strobe(slot_strobe), .underflow(underflow)
    );

    always #4 clk = ~clk;

    // EP2 endpoint model drops its head byte on an edge with slrd high and empty low
    always @(posedge clk) begin
        if (!reset && !usb_ep2_empty && usb_slrd) begin
            void'(ep2_q.pop_front());
        end
        if (ep2_q.size() != 0) begin
            usb_data_out  <= ep2_q[0];
            usb_ep2_empty <= 1'b0;
        end else begin
            usb_ep2_empty <= 1'b1;
        end
    end

    // Every strobed lane must match the head of its port queue
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!reset && slot_strobe[p]) begin
                assert (exp_q[p].size() != 0) else begin
                    $display("Unexpected strobe on port %0d at t=%0t, no byte outstanding",
                             p, $time);
                    errors++;
                end
                if (exp_q[p].size() != 0) begin
                    assert (slot_data_out[p*SAMPLE_W +: SAMPLE_W] == exp_q[p][0]) else begin
                        $display("FAILED t=%0t slot_data_out[%0d] got 0x%0h expected 0x%0h",
                                 $time, p, slot_data_out[p*SAMPLE_W +: SAMPLE_W], exp_q[p][0]);
                        errors++;
                    end
                    void'(exp_q[p].pop_front());
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, DUT stopped delivering", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == start_errors) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - start_errors);
        end
        start_errors = errors;
    endtask

    task automatic wait_port_drained(input int port);
        while (exp_q[port].size() != 0) @(negedge clk);
    endtask

    task automatic wait_all_drained();
        while (ep2_q.size() != 0) @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            wait_port_drained(p);
        end
    endtask

    task automatic check_idle(input string when);
        check_value({"usb_slrd ", when}, usb_slrd, 0);
        check_value({"usb_sloe ", when}, usb_sloe, 0);
        // EP2 is FIFOADR code 00
        check_value({"usb_addr ", when}, usb_addr, 2'b00);
        check_value({"slot_strobe ", when}, slot_strobe, 0);
        check_value({"underflow ", when}, underflow, 0);
    endtask

    initial begin
        int cycle;
        int last;
        int n;
        bit stalled;
        reset         = 1'b1;
        usb_ep2_empty = 1'b1;
        usb_data_out  = '0;

        repeat (8) begin
            @(negedge clk);
            check_idle("in reset");
        end
        @(posedge clk) reset <= 1'b0;
        @(negedge clk);
        check_idle("after reset");
        // Port 1 gets data while every port is still off
        send_data(1, 6);
        repeat (40) begin
            @(negedge clk);
            check_value("slot_strobe", slot_strobe, 0);
        end
        end_test("reset_state");

        send_cmd(REG_PORT_ENABLE, 8'h0f);
        for (int p = 0; p < NUM_PORTS; p++) begin
            send_data(p, 1 + int'(next_random() % 12));
        end
        wait_all_drained();
        end_test("routing_order");

        send_cmd(REG_PORT_ENABLE, 8'h01);
        // Write to an unknown address changes nothing
        send_cmd(3'd5, 8'hff);
        send_data(2, 9);
        while (ep2_q.size() != 0) @(negedge clk);
        repeat (30) begin
            @(negedge clk);
            check_value("slot_strobe[2]", slot_strobe[2], 0);
        end
        send_cmd(REG_PORT_ENABLE, 8'h05);
        wait_port_drained(2);
        end_test("command_enable");

        send_cmd(REG_SAMPLE_DIV, 8'(PACE_DIV));
        send_data(0, 24);
        cycle = 0;
        last  = 0;
        n     = 0;
        while (exp_q[0].size() != 0) begin
            @(negedge clk);
            cycle++;
            if (slot_strobe[0]) begin
                n++;
                if (n > 1) begin
                    check_value("strobe interval port 0", cycle - last, PACE_DIV + 1);
                end
                last = cycle;
            end
        end
        end_test("sample_pacing");

        // Fill port 3 while off, then feed it at the slowest rate
        send_cmd(REG_PORT_ENABLE, 8'h00);
        send_cmd(REG_SAMPLE_DIV, 8'(MAX_DIV));
        send_data(3, FIFO_DEPTH + 1);
        send_cmd(REG_PORT_ENABLE, 8'h08);
        send_data(3, 14);
        stalled = 1'b0;
        while (exp_q[3].size() != 0) begin
            @(negedge clk);
            if (!usb_slrd && !usb_ep2_empty) begin
                stalled = 1'b1;
            end
        end
        assert (stalled) else begin
            $display("usb_slrd never went low while EP2 still held bytes for a full FIFO");
            errors++;
        end
        end_test("back_pressure");

        wait_all_drained();
        @(posedge clk) reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("underflow after reset", underflow, 0);
        send_data(0, FIFO_DEPTH);
        send_data(1, 2);
        send_cmd(REG_PORT_ENABLE, 8'h03);
        wait_port_drained(1);
        repeat (2 * (RESET_DIV + 1) + 2) @(negedge clk);
        check_value("underflow port 1 starved", underflow, 4'b0010);
        wait_port_drained(0);
        repeat (RESET_DIV + 3) @(negedge clk);
        check_value("underflow both starved", underflow, 4'b0011);
        end_test("underflow");

        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/usb_audio_top.sv ====
// Playback only; usb_ifclk must be clk, NUM_PORTS at most 4, FIFO_DEPTH a power of two
`timescale 1ns/1ps

module usb_audio_top
    import audio_cfg_pkg::*;
#(
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          usb_ep2_empty,
    input  logic [7:0]                    usb_data_out,
    output logic                          usb_slrd,
    output logic                          usb_sloe,
    output logic [1:0]                    usb_addr,
    output logic [NUM_PORTS*SAMPLE_W-1:0] slot_data_out,
    output logic [NUM_PORTS-1:0]          slot_strobe,
    output logic [NUM_PORTS-1:0]          underflow
);

    //  Reader to FIFOs and registers
    logic [SAMPLE_W-1:0]   fifo_wr_data;
    logic [NUM_PORTS-1:0]  fifo_wr;
    logic [NUM_PORTS-1:0]  fifo_full;
    logic                  cfg_wr;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_data;

    //  Registers to drivers
    logic [NUM_PORTS-1:0]  port_enable;
    logic [DIV_W-1:0]      sample_div;

    //  Per-port FIFO to driver
    logic [SAMPLE_W-1:0]   fifo_rd_data [NUM_PORTS];
    logic [NUM_PORTS-1:0]  fifo_empty;
    logic [NUM_PORTS-1:0]  fifo_rd;

    fx2_ep2_reader #(.NUM_PORTS(NUM_PORTS)) u_reader (
        .clk(clk), .reset(reset),
        .usb_ep2_empty(usb_ep2_empty), .usb_data_out(usb_data_out), .fifo_full(fifo_full),
        .usb_slrd(usb_slrd), .usb_sloe(usb_sloe), .usb_addr(usb_addr),
        .fifo_wr_data(fifo_wr_data), .fifo_wr(fifo_wr),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data)
    );

    config_registers #(.NUM_PORTS(NUM_PORTS)) u_regs (
        .clk(clk), .reset(reset),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .port_enable(port_enable), .sample_div(sample_div)
    );

    //  One FIFO and slot driver per DAC port
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        sample_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
            .clk(clk), .reset(reset),
            .wr(fifo_wr[i]), .wr_data(fifo_wr_data), .rd(fifo_rd[i]),
            .rd_data(fifo_rd_data[i]), .full(fifo_full[i]), .empty(fifo_empty[i])
        );

        dac_slot_driver u_driver (
            .clk(clk), .reset(reset),
            .enable(port_enable[i]), .sample_div(sample_div),
            .fifo_empty(fifo_empty[i]), .fifo_data(fifo_rd_data[i]), .fifo_rd(fifo_rd[i]),
            .slot_data(slot_data_out[i*SAMPLE_W +: SAMPLE_W]),
            .slot_strobe(slot_strobe[i]), .underflow(underflow[i])
        );
    end

endmodule

// ==== src/fx2_ep2_reader.sv ====
// Requires usb_ifclk == clk; payload bytes addressed to ports >= NUM_PORTS are read and dropped
`timescale 1ns/1ps

module fx2_ep2_reader
    import usb_proto_pkg::*;
    import audio_cfg_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  usb_ep2_empty,
    input  logic [USB_DATA_W-1:0] usb_data_out,
    input  logic [NUM_PORTS-1:0]  fifo_full,
    output logic                  usb_slrd,
    output logic                  usb_sloe,
    output logic [FIFOADR_W-1:0]  usb_addr,
    output logic [SAMPLE_W-1:0]   fifo_wr_data,
    output logic [NUM_PORTS-1:0]  fifo_wr,
    output logic                  cfg_wr,
    output logic [CFG_ADDR_W-1:0] cfg_addr,
    output logic [CFG_DATA_W-1:0] cfg_data
);

    //  Parser states
    localparam logic [1:0] ST_HEADER    = 2'd0;
    localparam logic [1:0] ST_PAYLOAD   = 2'd1;
    localparam logic [1:0] ST_CMD_VALUE = 2'd2;

    logic [1:0]            state;
    ep2_header_u           hdr;
    logic [PORT_SEL_W-1:0] cur_port;
    logic [LEN_W-1:0]      remaining;
    logic                  hold_valid;
    logic [PORT_SEL_W-1:0] hold_port;
    logic                  hold_full;
    logic                  stall;
    logic                  take;
    logic                  port_ok;

    assign hdr      = usb_data_out;
    assign usb_addr = EP2_FIFO_ADDR;
    assign port_ok  = int'(cur_port) < NUM_PORTS;

    //  Held byte drains into its FIFO as soon as that FIFO has room
    always_comb begin
        hold_full = 1'b0;
        fifo_wr   = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (hold_port == PORT_SEL_W'(p)) begin
                hold_full  = fifo_full[p];
                fifo_wr[p] = hold_valid & ~fifo_full[p];
            end
        end
    end

    //  Only payload bytes wait on a blocked holding register
    assign stall    = (state == ST_PAYLOAD) & hold_valid & hold_full;
    assign usb_slrd = ~usb_ep2_empty & ~stall;
    assign usb_sloe = usb_slrd;
    assign take     = usb_slrd;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_HEADER;
            hold_valid <= 1'b0;
            cfg_wr     <= 1'b0;
        end else begin
            cfg_wr <= 1'b0;
            if (take && state == ST_PAYLOAD && port_ok) begin
                hold_valid <= 1'b1;
            end else if (|fifo_wr) begin
                hold_valid <= 1'b0;
            end

            if (take) begin
                case (state)
                    ST_HEADER: begin
                        if (hdr.data.kind == HDR_KIND_DATA) begin
                            state <= ST_PAYLOAD;
                        end else begin
                            state <= ST_CMD_VALUE;
                        end
                    end
                    ST_PAYLOAD: begin
                        if (remaining == LEN_W'(1)) begin
                            state <= ST_HEADER;
                        end
                    end
                    default: begin
                        cfg_wr <= 1'b1;
                        state  <= ST_HEADER;
                    end
                endcase
            end
        end
    end

    //  Header fields and payload bytes
    always_ff @(posedge clk) begin
        if (take) begin
            if (state == ST_HEADER) begin
                cur_port  <= hdr.data.port;
                cfg_addr  <= hdr.cmd.addr;
                //  Zero length counts as one byte
                remaining <= (hdr.data.len == '0) ? LEN_W'(1) : hdr.data.len;
            end else if (state == ST_PAYLOAD) begin
                remaining <= remaining - LEN_W'(1);
                if (port_ok) begin
                    hold_port    <= cur_port;
                    fifo_wr_data <= usb_data_out;
                end
            end else begin
                cfg_data <= usb_data_out;
            end
        end
    end

endmodule

// ==== src/config_registers.sv ====
// Write-only register file; cfg_data bits above NUM_PORTS are ignored on an enable write
`timescale 1ns/1ps

module config_registers
    import audio_cfg_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_wr,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_data,
    output logic [NUM_PORTS-1:0]  port_enable,
    output logic [DIV_W-1:0]      sample_div
);

    logic wr_enable_reg;
    logic wr_div_reg;

    //  Address decode
    always_comb begin
        wr_enable_reg = 1'b0;
        wr_div_reg    = 1'b0;
        if (cfg_wr) begin
            case (cfg_addr)
                REG_PORT_ENABLE: wr_enable_reg = 1'b1;
                REG_SAMPLE_DIV:  wr_div_reg    = 1'b1;
                default: begin
                    wr_enable_reg = 1'b0;
                    wr_div_reg    = 1'b0;
                end
            endcase
        end
    end

    //  All ports off after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            port_enable <= '0;
        end else if (wr_enable_reg) begin
            port_enable <= cfg_data[NUM_PORTS-1:0];
        end
    end

    //  Divider shared by every port
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_div <= SAMPLE_DIV_RESET;
        end else if (wr_div_reg) begin
            sample_div <= DIV_W'(cfg_data);
        end
    end

endmodule

// ==== src/dac_slot_driver.sv ====
// Underflow is sticky until reset; a divider change takes effect on the running count
`timescale 1ns/1ps

module dac_slot_driver
    import audio_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic [DIV_W-1:0]    sample_div,
    input  logic                fifo_empty,
    input  logic [SAMPLE_W-1:0] fifo_data,
    output logic                fifo_rd,
    output logic [SAMPLE_W-1:0] slot_data,
    output logic                slot_strobe,
    output logic                underflow
);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    //  Tick every sample_div+1 cycles while enabled
    assign tick    = enable & (div_cnt >= sample_div);
    assign fifo_rd = tick & ~fifo_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            slot_strobe <= 1'b0;
            underflow   <= 1'b0;
        end else begin
            //  Held at zero while disabled, so enabling restarts the count
            if (!enable || tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            slot_strobe <= fifo_rd;
            if (tick && fifo_empty) begin
                underflow <= 1'b1;
            end
        end
    end

    //  Last sample stays on the lane between strobes
    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            slot_data <= fifo_data;
        end
    end

endmodule

// ==== src/sample_fifo.sv ====
// DEPTH must be a power of two and at least 2; writes when full and reads when empty are ignored
`timescale 1ns/1ps

module sample_fifo
    import audio_cfg_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr,
    input  logic [SAMPLE_W-1:0] wr_data,
    input  logic                rd,
    output logic [SAMPLE_W-1:0] rd_data,
    output logic                full,
    output logic                empty
);

    localparam int AW = $clog2(DEPTH);

    logic [SAMPLE_W-1:0] mem [DEPTH];
    //  Extra top bit separates full from empty
    logic [AW:0]         wr_ptr;
    logic [AW:0]         rd_ptr;
    logic                do_wr;
    logic                do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_wr = wr & ~full;
    assign do_rd = rd & ~empty;

    //  Head of queue shown ahead
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //  Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

endmodule

// ==== src/usb_proto_pkg.sv ====
// EP2 byte protocol of one header byte followed by payload or one value byte; audio_cfg_pkg compiles first
package usb_proto_pkg;

    //  FX2 slave FIFO bus
    localparam int USB_DATA_W = 8;
    localparam int FIFOADR_W  = 2;
    localparam logic [FIFOADR_W-1:0] EP2_FIFO_ADDR = 2'b00;

    //  Header field widths
    localparam int PORT_SEL_W = 2;
    localparam int LEN_W      = 5;
    localparam int CMD_RSVD_W = 4;

    //  Kind bit at the top of the header byte
    localparam logic HDR_KIND_DATA = 1'b0;
    localparam logic HDR_KIND_CMD  = 1'b1;

    //  Same byte read as data header or command header depending on kind
    typedef union packed {
        struct packed {
            logic                  kind;
            logic [PORT_SEL_W-1:0] port;
            logic [LEN_W-1:0]      len;
        } data;
        struct packed {
            logic                               kind;
            logic [audio_cfg_pkg::CFG_ADDR_W-1:0] addr;
            logic [CMD_RSVD_W-1:0]              rsvd;
        } cmd;
    } ep2_header_u;

endpackage

// ==== src/audio_cfg_pkg.sv ====
// Register map and widths of the DAC playback path; sample width fixed to one byte
package audio_cfg_pkg;

    //  Audio sample lane
    localparam int SAMPLE_W = 8;

    //  Configuration register bus
    localparam int CFG_ADDR_W = 3;
    localparam int CFG_DATA_W = 8;

    //  Sample rate divider gives a tick every div+1 cycles
    localparam int DIV_W = 8;
    localparam logic [DIV_W-1:0] SAMPLE_DIV_RESET = 8'd3;

    //  Register addresses; others are ignored
    localparam logic [CFG_ADDR_W-1:0] REG_PORT_ENABLE = 3'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_SAMPLE_DIV  = 3'd1;

endpackage
